// ==== include/udp_arb_settings.svh ====
// Build-time sizes for the UDP arbitrated multiplexer.
// Include this file wherever port count or datapath widths are needed.
`ifndef UDP_ARB_SETTINGS_SVH
`define UDP_ARB_SETTINGS_SVH

// number of arbitrated inputs.
`define UDP_ARB_PORTS 4

// payload datapath width in bits.
`define UDP_DATA_WIDTH 64

// byte enables, one per data byte.
`define UDP_KEEP_WIDTH 8

// cycle bound for every testbench wait loop.
`define UDP_TB_TIMEOUT 2000

`endif

// ==== hw/udp_arb_pkg.sv ====
// Shared types for the UDP arbitrated multiplexer.
// Modules import it inside their body; port lists use scoped names.
`include "udp_arb_settings.svh"

package udp_arb_pkg;

    // udp header, trimmed to the fields this mux forwards.
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // input number and one-bit-per-input mask.
    typedef logic [$clog2(`UDP_ARB_PORTS)-1:0] port_idx_t;
    typedef logic [`UDP_ARB_PORTS-1:0] port_mask_t;

    // payload beat fields.
    typedef logic [`UDP_DATA_WIDTH-1:0] data_t;
    typedef logic [`UDP_KEEP_WIDTH-1:0] keep_t;

endpackage

// ==== hw/udp_stream_ifs.sv ====
// Internal bundles of the UDP mux.
// arb_grant_if joins the arbiter and the frame selector;
// udp_payload_if carries the chosen payload to the output skid stage.
`timescale 1ns/100ps
`include "udp_arb_settings.svh"

interface arb_grant_if;
    udp_arb_pkg::port_mask_t request;
    udp_arb_pkg::port_mask_t acknowledge;
    udp_arb_pkg::port_mask_t grant;
    logic                    grant_valid;
    udp_arb_pkg::port_idx_t  grant_index;

    modport arbiter (
        input  request,
        input  acknowledge,
        output grant,
        output grant_valid,
        output grant_index
    );

    modport select (
        output request,
        output acknowledge,
        input  grant,
        input  grant_valid,
        input  grant_index
    );
endinterface

interface udp_payload_if;
    udp_arb_pkg::data_t tdata;
    udp_arb_pkg::keep_t tkeep;
    logic               tvalid;
    logic               tready;
    logic               tlast;
    logic               tuser;

    // beat moves when tvalid and tready are both high.
    modport source (
        output tdata, tkeep, tvalid, tlast, tuser,
        input  tready
    );

    modport sink (
        input  tdata, tkeep, tvalid, tlast, tuser,
        output tready
    );
endinterface

// ==== hw/udp_arbiter.sv ====
// Round-robin arbiter for the UDP mux.
// A grant is held until the granted input acknowledges the end of its
// frame, so frames from different inputs never interleave.
`timescale 1ns/100ps
`include "udp_arb_settings.svh"

module udp_arbiter (
    input logic        clk,
    input logic        rst,
    arb_grant_if.arbiter arb
);
    import udp_arb_pkg::*;

    localparam int PORTS = `UDP_ARB_PORTS;

    port_idx_t  last_index;
    port_mask_t grant_q;
    port_idx_t  grant_index_q;
    logic       grant_valid_q;

    logic       found;
    port_idx_t  pick;
    logic       grant_done;

    // search starts one above the last winner and wraps around.
    always_comb begin
        int pos;
        found = 1'b0;
        pick  = '0;
        for (int k = 1; k <= PORTS; k++) begin
            pos = (int'(last_index) + k) % PORTS;
            if (!found && arb.request[pos]) begin
                found = 1'b1;
                pick  = port_idx_t'(pos);
            end
        end
    end

    // current frame finished on this cycle.
    assign grant_done = |(grant_q & arb.acknowledge);

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_valid_q <= 1'b0;
            grant_q       <= '0;
            grant_index_q <= '0;
            // points at the last input so input 0 wins first.
            last_index    <= port_idx_t'(PORTS - 1);
        end else if (!grant_valid_q || grant_done) begin
            // free, or releasing: a new winner can take the same edge.
            grant_valid_q <= found;
            grant_q       <= found ? (port_mask_t'(1) << pick) : '0;
            grant_index_q <= pick;
            if (found) begin
                last_index <= pick;
            end
        end
    end

    assign arb.grant       = grant_q;
    assign arb.grant_valid = grant_valid_q;
    assign arb.grant_index = grant_index_q;

endmodule

// ==== hw/udp_frame_select.sv ====
// Frame selector of the UDP mux.
// Turns header valids into arbiter requests, accepts the granted header
// into the output header register and steers the granted payload to the
// skid stage while that frame is open.
`timescale 1ns/100ps
`include "udp_arb_settings.svh"

module udp_frame_select (
    input  logic                                                clk,
    input  logic                                                rst,
    arb_grant_if.select                                         arb,

    input  udp_arb_pkg::port_mask_t                             in_hdr_valid,
    output udp_arb_pkg::port_mask_t                             in_hdr_ready,
    input  udp_arb_pkg::udp_hdr_t [`UDP_ARB_PORTS-1:0]          in_hdr,
    input  logic [`UDP_ARB_PORTS-1:0][`UDP_DATA_WIDTH-1:0]      in_tdata,
    input  logic [`UDP_ARB_PORTS-1:0][`UDP_KEEP_WIDTH-1:0]      in_tkeep,
    input  udp_arb_pkg::port_mask_t                             in_tvalid,
    output udp_arb_pkg::port_mask_t                             in_tready,
    input  udp_arb_pkg::port_mask_t                             in_tlast,
    input  udp_arb_pkg::port_mask_t                             in_tuser,

    output logic                                                out_hdr_valid,
    input  logic                                                out_hdr_ready,
    output udp_arb_pkg::udp_hdr_t                               out_hdr,

    udp_payload_if.source                                       pay
);
    import udp_arb_pkg::*;

    port_idx_t sel;
    udp_hdr_t  hdr_q;
    logic      hdr_valid_q;
    logic      frame_open;
    logic      hdr_slot_free;
    logic      hdr_accept;
    logic      last_xfer;

    assign sel = arb.grant_index;

    // header valid is the request, tlast transfer the release.
    assign arb.request     = in_hdr_valid;
    assign arb.acknowledge = in_tvalid & in_tready & in_tlast;

    // header register empty, or emptied on this cycle.
    assign hdr_slot_free = !hdr_valid_q || out_hdr_ready;
    assign in_hdr_ready  = (arb.grant_valid && !frame_open && hdr_slot_free) ? arb.grant : '0;
    assign hdr_accept    = |(in_hdr_ready & in_hdr_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_valid_q <= 1'b0;
        end else if (hdr_accept) begin
            hdr_valid_q <= 1'b1;
        end else if (out_hdr_ready) begin
            hdr_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            hdr_q <= in_hdr[sel];
        end
    end

    assign out_hdr_valid = hdr_valid_q;
    assign out_hdr       = hdr_q;

    // frame opens with its header and closes on the tlast beat.
    assign last_xfer = pay.tvalid && pay.tready && pay.tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_open <= 1'b0;
        end else if (hdr_accept) begin
            frame_open <= 1'b1;
        end else if (last_xfer) begin
            frame_open <= 1'b0;
        end
    end

    // payload mux, valid only inside an open frame.
    assign pay.tdata  = in_tdata[sel];
    assign pay.tkeep  = in_tkeep[sel];
    assign pay.tlast  = in_tlast[sel];
    assign pay.tuser  = in_tuser[sel];
    assign pay.tvalid = frame_open && in_tvalid[sel];

    // only the granted input sees ready.
    assign in_tready = (frame_open && pay.tready) ? arb.grant : '0;

endmodule

// ==== hw/udp_payload_reg.sv ====
// Output skid register for the UDP payload stream.
// One register stage of latency; a second entry absorbs the beat that
// arrives while the output stalls, so input ready can come from a flop.
`timescale 1ns/100ps

module udp_payload_reg (
    input  logic                clk,
    input  logic                rst,
    udp_payload_if.sink         pay,

    output udp_arb_pkg::data_t  out_tdata,
    output udp_arb_pkg::keep_t  out_tkeep,
    output logic                out_tvalid,
    input  logic                out_tready,
    output logic                out_tlast,
    output logic                out_tuser
);
    import udp_arb_pkg::*;

    data_t main_tdata;
    keep_t main_tkeep;
    logic  main_tlast;
    logic  main_tuser;
    logic  main_valid;

    data_t skid_tdata;
    keep_t skid_tkeep;
    logic  skid_tlast;
    logic  skid_tuser;
    logic  skid_valid;

    logic  out_free;
    logic  in_xfer;

    // ready straight from the skid flop.
    assign pay.tready = !skid_valid;
    assign in_xfer    = pay.tvalid && !skid_valid;
    assign out_free   = out_tready || !main_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (!skid_valid) begin
            if (out_free) begin
                main_valid <= pay.tvalid;
            end else if (in_xfer) begin
                skid_valid <= 1'b1;
            end
        end else if (out_tready) begin
            // skid holds the older beat, move it forward.
            main_valid <= 1'b1;
            skid_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!skid_valid && out_free) begin
            {main_tdata, main_tkeep, main_tlast, main_tuser} <=
                {pay.tdata, pay.tkeep, pay.tlast, pay.tuser};
        end else if (skid_valid && out_tready) begin
            {main_tdata, main_tkeep, main_tlast, main_tuser} <=
                {skid_tdata, skid_tkeep, skid_tlast, skid_tuser};
        end
        if (in_xfer && !out_free) begin
            {skid_tdata, skid_tkeep, skid_tlast, skid_tuser} <=
                {pay.tdata, pay.tkeep, pay.tlast, pay.tuser};
        end
    end

    assign out_tdata  = main_tdata;
    assign out_tkeep  = main_tkeep;
    assign out_tvalid = main_valid;
    assign out_tlast  = main_tlast;
    assign out_tuser  = main_tuser;

endmodule

// ==== hw/udp_arb_mux.sv ====
// Four-input arbitrated multiplexer for UDP frames, 64-bit payload.
// Inputs are packed arrays indexed by input number; the output is one
// header valid/ready channel plus one AXI-stream payload channel.
`timescale 1ns/100ps
`include "udp_arb_settings.svh"

module udp_arb_mux (
    input  logic                                            clk,
    input  logic                                            rst,

    // frame inputs.
    input  udp_arb_pkg::port_mask_t                         in_hdr_valid,
    output udp_arb_pkg::port_mask_t                         in_hdr_ready,
    input  udp_arb_pkg::udp_hdr_t [`UDP_ARB_PORTS-1:0]      in_hdr,
    input  logic [`UDP_ARB_PORTS-1:0][`UDP_DATA_WIDTH-1:0]  in_tdata,
    input  logic [`UDP_ARB_PORTS-1:0][`UDP_KEEP_WIDTH-1:0]  in_tkeep,
    input  udp_arb_pkg::port_mask_t                         in_tvalid,
    output udp_arb_pkg::port_mask_t                         in_tready,
    input  udp_arb_pkg::port_mask_t                         in_tlast,
    input  udp_arb_pkg::port_mask_t                         in_tuser,

    // frame output.
    output logic                                            out_hdr_valid,
    input  logic                                            out_hdr_ready,
    output udp_arb_pkg::udp_hdr_t                           out_hdr,
    output logic [`UDP_DATA_WIDTH-1:0]                      out_tdata,
    output logic [`UDP_KEEP_WIDTH-1:0]                      out_tkeep,
    output logic                                            out_tvalid,
    input  logic                                            out_tready,
    output logic                                            out_tlast,
    output logic                                            out_tuser
);

    arb_grant_if   arb_if ();
    udp_payload_if pay_if ();

    udp_arbiter arb_i (
        .clk (clk),
        .rst (rst),
        .arb (arb_if.arbiter)
    );

    udp_frame_select sel_i (
        .clk           (clk),
        .rst           (rst),
        .arb           (arb_if.select),
        .in_hdr_valid  (in_hdr_valid),
        .in_hdr_ready  (in_hdr_ready),
        .in_hdr        (in_hdr),
        .in_tdata      (in_tdata),
        .in_tkeep      (in_tkeep),
        .in_tvalid     (in_tvalid),
        .in_tready     (in_tready),
        .in_tlast      (in_tlast),
        .in_tuser      (in_tuser),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .out_hdr       (out_hdr),
        .pay           (pay_if.source)
    );

    // registered payload output.
    udp_payload_reg pay_reg_i (
        .clk        (clk),
        .rst        (rst),
        .pay        (pay_if.sink),
        .out_tdata  (out_tdata),
        .out_tkeep  (out_tkeep),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tlast  (out_tlast),
        .out_tuser  (out_tuser)
    );

endmodule

// ==== testbench/udp_arb_checker.sv ====
// Protocol assertions for the UDP mux, bound into udp_arb_mux.
// Covers idle outputs in reset, stable payload under stall and one-hot ready.
`timescale 1ns/100ps
`include "udp_arb_settings.svh"

module udp_arb_checker (
    input logic                          clk,
    input logic                          rst,
    input logic                          out_hdr_valid,
    input logic [`UDP_DATA_WIDTH-1:0]    out_tdata,
    input logic [`UDP_KEEP_WIDTH-1:0]    out_tkeep,
    input logic                          out_tvalid,
    input logic                          out_tready,
    input logic                          out_tlast,
    input logic                          out_tuser,
    input udp_arb_pkg::port_mask_t       in_tready
);
    // number of assertion failures so far.
    int assert_failures = 0;

    idle_in_reset: assert property (@(posedge clk)
        rst |-> (out_tvalid !== 1'b1 && out_hdr_valid !== 1'b1))
    else begin
        assert_failures++;
        $error("output valid high while reset is asserted");
    end

    // a stalled beat stays put until it is taken.
    stall_stable: assert property (@(posedge clk) disable iff (rst)
        (out_tvalid && !out_tready) |=>
            (out_tvalid && $stable({out_tdata, out_tkeep, out_tlast, out_tuser})))
    else begin
        assert_failures++;
        $error("output payload changed while stalled");
    end

    one_ready: assert property (@(posedge clk) disable iff (rst) $onehot0(in_tready))
    else begin
        assert_failures++;
        $error("more than one input sees tready");
    end

endmodule

bind udp_arb_mux udp_arb_checker checker_i (
    .clk           (clk),
    .rst           (rst),
    .out_hdr_valid (out_hdr_valid),
    .out_tdata     (out_tdata),
    .out_tkeep     (out_tkeep),
    .out_tvalid    (out_tvalid),
    .out_tready    (out_tready),
    .out_tlast     (out_tlast),
    .out_tuser     (out_tuser),
    .in_tready     (in_tready)
);

// ==== testbench/udp_arb_monitor.sv ====
// Output monitor of the UDP mux testbench.
// Drivers register expected frames per input; each output header is paired
// with the next finished payload frame and both are compared.
`timescale 1ns/100ps
`include "udp_arb_settings.svh"

module udp_arb_monitor (
    input logic                          clk,
    input logic                          rst,
    input logic                          out_hdr_valid,
    input logic                          out_hdr_ready,
    input udp_arb_pkg::udp_hdr_t         out_hdr,
    input logic [`UDP_DATA_WIDTH-1:0]    out_tdata,
    input logic [`UDP_KEEP_WIDTH-1:0]    out_tkeep,
    input logic                          out_tvalid,
    input logic                          out_tready,
    input logic                          out_tlast,
    input logic                          out_tuser
);
    import udp_arb_pkg::*;

    localparam int PORTS = `UDP_ARB_PORTS;
    localparam int DEPTH = 512;
    // upper source port bits of every test header.
    localparam logic [5:0] SRC_TAG = 6'b101000;

    typedef struct packed {
        data_t tdata;
        keep_t tkeep;
        logic  tlast;
        logic  tuser;
    } beat_t;

    udp_hdr_t exp_hdr [PORTS][DEPTH];
    beat_t    exp_beat [PORTS][DEPTH];
    int       hdr_wr [PORTS];
    int       hdr_rd [PORTS];
    int       beat_wr [PORTS];
    int       beat_rd [PORTS];
    udp_hdr_t got_hdr [$];
    beat_t    got_beat [$];
    int       got_frames;
    int       frames_seen;
    int       error_count;
    int       src_log [DEPTH];

    task expect_header(input int idx, input udp_hdr_t hdr);
        exp_hdr[idx][hdr_wr[idx]] = hdr;
        hdr_wr[idx]++;
    endtask

    task expect_beat(input int idx, input beat_t beat);
        exp_beat[idx][beat_wr[idx]] = beat;
        beat_wr[idx]++;
    endtask

    function int pending_frames();
        int sum;
        sum = 0;
        for (int i = 0; i < PORTS; i++) begin
            sum += hdr_wr[i] - hdr_rd[i];
        end
        return sum;
    endfunction

    task compare_value(input string name, input logic [127:0] expected, input logic [127:0] got);
        if (got !== expected) begin
            $display("Error at %0t: %s expected %0h got %0h", $time, name, expected, got);
            error_count++;
        end
    endtask

    task check_frame(input udp_hdr_t hdr);
        int    idx;
        logic  known;
        logic  done;
        beat_t got;
        beat_t exp;
        idx   = int'(hdr.src_port[9:8]);
        known = 1'b1;
        src_log[frames_seen] = idx;
        frames_seen++;
        if (hdr.src_port[15:10] != SRC_TAG) begin
            $display("output header at %0t names no input, source port %0h", $time, hdr.src_port);
            error_count++;
            known = 1'b0;
        end else if (hdr_rd[idx] >= hdr_wr[idx]) begin
            $display("output frame at %0t from input %0d was never sent", $time, idx);
            error_count++;
            known = 1'b0;
        end else begin
            compare_value("out_hdr", exp_hdr[idx][hdr_rd[idx]], hdr);
            hdr_rd[idx]++;
        end
        // every beat up to tlast must come from the header's input.
        done = 1'b0;
        while (!done && got_beat.size() > 0) begin
            got  = got_beat.pop_front();
            done = got.tlast;
            if (known && beat_rd[idx] >= beat_wr[idx]) begin
                $display("more beats arrived at %0t than input %0d sent", $time, idx);
                error_count++;
                known = 1'b0;
            end else if (known) begin
                exp = exp_beat[idx][beat_rd[idx]];
                beat_rd[idx]++;
                compare_value("out_tdata", exp.tdata, got.tdata);
                compare_value("out_tkeep", exp.tkeep, got.tkeep);
                compare_value("out_tlast", exp.tlast, got.tlast);
                compare_value("out_tuser", exp.tuser, got.tuser);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (out_hdr_valid && out_hdr_ready) begin
                got_hdr.push_back(out_hdr);
            end
            if (out_tvalid && out_tready) begin
                got_beat.push_back({out_tdata, out_tkeep, out_tlast, out_tuser});
                if (out_tlast) begin
                    got_frames++;
                end
            end
            // header and payload of a frame may leave in either order.
            while (got_hdr.size() > 0 && got_frames > 0) begin
                check_frame(got_hdr.pop_front());
                got_frames--;
            end
        end
    end

endmodule

// ==== testbench/tb_udp_arb_mux.sv ====
// Testbench for the four-input UDP frame mux.
// Runs a table of traffic rows, each with its own frame mix and output
// back-pressure; udp_arb_monitor checks every frame that comes out.
`timescale 1ns/100ps
`include "udp_arb_settings.svh"

module tb_udp_arb_mux;
    import udp_arb_pkg::*;

    localparam int PORTS   = `UDP_ARB_PORTS;
    localparam int TIMEOUT = `UDP_TB_TIMEOUT;
    localparam int N_ROWS  = 5;

    // frames and beats hold one hex digit per input, input 3 leftmost.
    typedef struct packed {
        logic [15:0] frames;
        logic [15:0] beats;
        logic [3:0]  part;
        logic [3:0]  user;
        logic        bp;
    } row_t;

    logic                                   clk;
    logic                                   rst;
    port_mask_t                             in_hdr_valid;
    port_mask_t                             in_hdr_ready;
    udp_hdr_t [PORTS-1:0]                   in_hdr;
    logic [PORTS-1:0][`UDP_DATA_WIDTH-1:0]  in_tdata;
    logic [PORTS-1:0][`UDP_KEEP_WIDTH-1:0]  in_tkeep;
    port_mask_t                             in_tvalid;
    port_mask_t                             in_tready;
    port_mask_t                             in_tlast;
    port_mask_t                             in_tuser;
    logic                                   out_hdr_valid;
    logic                                   out_hdr_ready;
    udp_hdr_t                               out_hdr;
    logic [`UDP_DATA_WIDTH-1:0]             out_tdata;
    logic [`UDP_KEEP_WIDTH-1:0]             out_tkeep;
    logic                                   out_tvalid;
    logic                                   out_tready;
    logic                                   out_tlast;
    logic                                   out_tuser;

    row_t rows [N_ROWS];
    logic bp_mode;
    logic timed_out;
    int   tb_errors;
    int   prev_last;
    int   seq [PORTS];

    udp_arb_mux dut_i (.*);
    udp_arb_monitor mon_i (.*);

    always #5 clk = ~clk;

    // output ready, random under back-pressure.
    always @(posedge clk) begin
        #1;
        out_hdr_ready = bp_mode ? 1'($urandom_range(1, 0)) : 1'b1;
        out_tready    = bp_mode ? 1'($urandom_range(1, 0)) : 1'b1;
    end

    function int error_total();
        return tb_errors + mon_i.error_count + dut_i.checker_i.assert_failures;
    endfunction

    task flag_wrong_value(input string name, input int expected, input int got);
        $display("Error at %0t: %s expected %0d got %0d", $time, name, expected, got);
        tb_errors++;
    endtask

    // returns 1 ns after the edge that took the header or beat.
    task automatic wait_accept(input int idx, input logic header, output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < TIMEOUT) begin
            @(posedge clk);
            ok = header ? in_hdr_ready[idx] : in_tready[idx];
            n++;
        end
        if (!ok) begin
            $display("timeout: input %0d never saw %s ready", idx, header ? "header" : "payload");
            timed_out = 1'b1;
            tb_errors++;
        end
        #1;
    endtask

    task automatic drive_input(input int idx, input int frames, input int beats,
                               input logic part, input logic user);
        udp_hdr_t                   hdr;
        logic [`UDP_DATA_WIDTH-1:0] data;
        logic                       last;
        logic                       ok;
        ok = 1'b1;
        for (int f = 0; f < frames && ok && !timed_out; f++) begin
            hdr.src_ip   = $urandom;
            hdr.dst_ip   = $urandom;
            hdr.src_port = {6'b101000, idx[1:0], seq[idx][7:0]};
            hdr.dst_port = 16'd4791;
            hdr.length   = 16'(8 + 8 * beats);
            hdr.checksum = 16'($urandom);
            mon_i.expect_header(idx, hdr);
            in_hdr[idx]       = hdr;
            in_hdr_valid[idx] = 1'b1;
            wait_accept(idx, 1'b1, ok);
            in_hdr_valid[idx] = 1'b0;
            for (int b = 0; b < beats && ok; b++) begin
                last = (b == beats - 1);
                data = {8'(idx), 8'(seq[idx]), 16'(b), 32'($urandom)};
                in_tdata[idx]  = data;
                in_tkeep[idx]  = (last && part) ? 8'h0f : 8'hff;
                in_tlast[idx]  = last;
                in_tuser[idx]  = last && user;
                in_tvalid[idx] = 1'b1;
                mon_i.expect_beat(idx, {data, in_tkeep[idx], last, in_tuser[idx]});
                wait_accept(idx, 1'b0, ok);
            end
            in_tvalid[idx] = 1'b0;
            in_tlast[idx]  = 1'b0;
            seq[idx]++;
        end
    endtask

    // idle DUT: header valid seen on edge 1, output header valid on edge 3.
    task automatic check_header_latency();
        int n;
        int cycles;
        n = 0;
        @(posedge clk);
        while (!in_hdr_valid[0] && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!in_hdr_valid[0]) begin
            $display("timeout: input 0 never raised its header valid");
            tb_errors++;
        end
        cycles = 1;
        while (!out_hdr_valid && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!out_hdr_valid) begin
            $display("timeout: out_hdr_valid never rose after a lone header");
            tb_errors++;
        end else if (cycles != 3) begin
            flag_wrong_value("out_hdr_valid latency", 3, cycles);
        end
    endtask

    task automatic run_row(input int r);
        row_t row;
        int   first;
        int   total;
        int   n;
        logic rotation;
        row   = rows[r];
        first = mon_i.frames_seen;
        total = 0;
        for (int i = 0; i < PORTS; i++) begin
            total += row.frames[i*4 +: 4];
        end
        rotation = row.frames[3:0] != 0 && row.frames == {4{row.frames[3:0]}};
        @(negedge clk);
        bp_mode = row.bp;
        @(posedge clk);
        #1;
        fork
            drive_input(0, row.frames[3:0], row.beats[3:0], row.part[0], row.user[0]);
            drive_input(1, row.frames[7:4], row.beats[7:4], row.part[1], row.user[1]);
            drive_input(2, row.frames[11:8], row.beats[11:8], row.part[2], row.user[2]);
            drive_input(3, row.frames[15:12], row.beats[15:12], row.part[3], row.user[3]);
            if (r == 0) check_header_latency();
        join
        n = 0;
        while (mon_i.frames_seen < first + total && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (mon_i.frames_seen < first + total) begin
            $display("timeout: row %0d is missing output frames", r);
            tb_errors++;
            timed_out = 1'b1;
        end
        if (mon_i.pending_frames() != 0) begin
            $display("row %0d left %0d sent frames unmatched", r, mon_i.pending_frames());
            tb_errors++;
        end
        // all inputs busy, so sources rotate from one above the last winner.
        for (int k = 0; rotation && k < total && first + k < mon_i.frames_seen; k++) begin
            if (mon_i.src_log[first + k] != (prev_last + 1 + k) % PORTS) begin
                flag_wrong_value("out_hdr source input", (prev_last + 1 + k) % PORTS,
                                 mon_i.src_log[first + k]);
            end
        end
        // last winner known only for full rotations or input 0 alone.
        if (rotation) begin
            prev_last = (prev_last + total) % PORTS;
        end else if (total != 0 && total == row.frames[3:0]) begin
            prev_last = 0;
        end
        $display("row %0d: %0d frames sent, %0d checked, %0d errors so far",
                 r, total, mon_i.frames_seen - first, error_total());
    endtask

    initial begin
        void'($urandom(94));
        clk           = 1'b0;
        rst           = 1'b1;
        in_hdr_valid  = '0;
        in_hdr        = '0;
        in_tdata      = '0;
        in_tkeep      = '0;
        in_tvalid     = '0;
        in_tlast      = '0;
        in_tuser      = '0;
        out_hdr_ready = 1'b1;
        out_tready    = 1'b1;
        bp_mode       = 1'b0;
        timed_out     = 1'b0;
        tb_errors     = 0;
        prev_last     = PORTS - 1;
        rows[0] = '{frames: 16'h0001, beats: 16'h0002, part: 4'b0000, user: 4'b0000, bp: 1'b0};
        rows[1] = '{frames: 16'h3333, beats: 16'h4321, part: 4'b1010, user: 4'b0101, bp: 1'b0};
        rows[2] = '{frames: 16'h2222, beats: 16'h2525, part: 4'b1111, user: 4'b1111, bp: 1'b1};
        rows[3] = '{frames: 16'h4444, beats: 16'h1111, part: 4'b0000, user: 4'b1111, bp: 1'b0};
        rows[4] = '{frames: 16'h1302, beats: 16'h3161, part: 4'b0100, user: 4'b0010, bp: 1'b1};
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        if (out_hdr_valid !== 1'b0 || out_tvalid !== 1'b0) begin
            $display("outputs are not idle after reset");
            tb_errors++;
        end
        for (int r = 0; r < N_ROWS && !timed_out; r++) begin
            run_row(r);
        end
        $display("total: %0d frames checked, %0d errors", mon_i.frames_seen, error_total());
        if (error_total() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
hw/udp_arb_pkg.sv
hw/udp_stream_ifs.sv
hw/udp_arbiter.sv
hw/udp_frame_select.sv
hw/udp_payload_reg.sv
hw/udp_arb_mux.sv
testbench/udp_arb_checker.sv
testbench/udp_arb_monitor.sv
testbench/tb_udp_arb_mux.sv
